//--- src/sdr_settings.svh
`ifndef SDR_SETTINGS_SVH
`define SDR_SETTINGS_SVH

// Reduced array size keeps simulation small.
`define SDR_ROW_BITS 4
`define SDR_COL_BITS 5

// Cycles from the read command edge to the data sample, 2 or 3.
`define SDR_CAS_LATENCY 2

// Idle cycles between activate and the access command.
`define SDR_TRCD 2

// Wait after reset before the mode register load.
`define SDR_INIT_CYCLES 8

`define SDR_TAG_BITS 4

`endif

//--- src/sdr_pkg.sv
`include "sdr_settings.svh"

package sdr_pkg;

  // Pin pattern is {cs, ras, cas, we}, all active low.
  typedef enum logic [3:0] {
    cmd_nop       = 4'b0111,
    cmd_load_mode = 4'b0000,
    cmd_active    = 4'b0011,
    cmd_read      = 4'b0101,
    cmd_write     = 4'b0100
  } sdr_cmd_e;

  typedef enum logic [2:0] {
    st_init_wait,
    st_load_mode,
    st_idle,
    st_activate_wait,
    st_access
  } sdr_issue_state_e;

  // A set mask bit keeps the stored byte.
  typedef struct packed {
    logic                     wr;
    logic [1:0]               bank;
    logic [`SDR_ROW_BITS-1:0] row;
    logic [`SDR_COL_BITS-1:0] col;
    logic [15:0]              wdata;
    logic [1:0]               mask;
    logic [`SDR_TAG_BITS-1:0] tag;
  } sdr_req_t;

  typedef struct packed {
    sdr_req_t req;
    logic     miss;
  } sdr_plan_t;

  typedef struct packed {
    logic [15:0]              rdata;
    logic [`SDR_TAG_BITS-1:0] tag;
  } sdr_rsp_t;

endpackage

//--- src/sdr_row_tracker.sv
`include "sdr_settings.svh"

module sdr_row_tracker (
  input  logic              clk,
  input  logic              rst_n,
  input  sdr_pkg::sdr_req_t  req,
  input  logic              req_valid,
  output logic              req_ready,
  output sdr_pkg::sdr_plan_t plan,
  output logic              plan_valid,
  input  logic              plan_ready
);

  logic [`SDR_ROW_BITS-1:0] open_row [4];
  logic [3:0]               open_vld;
  logic                     issuer_up;
  logic                     take;
  logic                     miss;

  // Requests are held off until the issuer has finished its init sequence.
  assign req_ready = plan_ready || (!plan_valid && issuer_up);
  assign take      = req_valid && req_ready;

  // A bank with no open row always needs an activation.
  assign miss = !open_vld[req.bank] || (open_row[req.bank] != req.row);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      issuer_up <= 1'b0;
    end else if (plan_ready) begin
      issuer_up <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      plan_valid <= 1'b0;
      open_vld   <= '0;
    end else begin
      if (take) begin
        plan_valid          <= 1'b1;
        open_vld[req.bank]  <= 1'b1;
      end else if (plan_ready) begin
        plan_valid <= 1'b0;
      end
    end
  end

  // Open rows follow acceptance order, which is the issuer's activation order.
  always_ff @(posedge clk) begin
    if (take) begin
      plan.req           <= req;
      plan.miss          <= miss;
      open_row[req.bank] <= req.row;
    end
  end

endmodule

//--- src/sdr_cmd_issue.sv
`include "sdr_settings.svh"

module sdr_cmd_issue (
  input  logic                     clk,
  input  logic                     rst_n,
  input  sdr_pkg::sdr_plan_t       plan,
  input  logic                     plan_valid,
  output logic                     plan_ready,
  output logic                     cs,
  output logic                     ras,
  output logic                     cas,
  output logic                     we,
  output logic [12:0]              a,
  output logic [1:0]               ba,
  output logic [1:0]               dqm,
  output logic [15:0]              dq_wr,
  output logic                     dq_wr_en,
  output logic                     rd_issue,
  output logic [`SDR_TAG_BITS-1:0] rd_tag
);

  localparam int cnt_max = (`SDR_INIT_CYCLES > `SDR_TRCD) ? `SDR_INIT_CYCLES : `SDR_TRCD;
  localparam int cnt_w   = $clog2(cnt_max + 1);

  // Burst length one, sequential, CAS latency in a[6:4].
  localparam logic [12:0] mode_word = {6'b0, 3'(`SDR_CAS_LATENCY), 1'b0, 3'b000};

  sdr_pkg::sdr_issue_state_e state;
  sdr_pkg::sdr_cmd_e         cmd;
  sdr_pkg::sdr_plan_t        cur;
  logic [cnt_w-1:0]          cnt;

  assign plan_ready = (state == sdr_pkg::st_idle);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= sdr_pkg::st_init_wait;
      cnt   <= cnt_w'(`SDR_INIT_CYCLES - 1);
    end else begin
      case (state)
        sdr_pkg::st_init_wait: begin
          if (cnt == '0) state <= sdr_pkg::st_load_mode;
          else cnt <= cnt - 1'b1;
        end
        sdr_pkg::st_load_mode: state <= sdr_pkg::st_idle;
        sdr_pkg::st_idle: begin
          if (plan_valid && plan.miss) begin
            state <= sdr_pkg::st_activate_wait;
            cnt   <= cnt_w'(`SDR_TRCD);
          end else if (plan_valid) begin
            state <= sdr_pkg::st_access;
          end
        end
        // First cycle carries the activate, then TRCD nop cycles.
        sdr_pkg::st_activate_wait: begin
          if (cnt == '0) state <= sdr_pkg::st_access;
          else cnt <= cnt - 1'b1;
        end
        default: state <= sdr_pkg::st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (plan_valid && plan_ready) cur <= plan;
  end

  always_comb begin
    cmd      = sdr_pkg::cmd_nop;
    a        = '0;
    ba       = '0;
    dqm      = '0;
    dq_wr    = '0;
    dq_wr_en = 1'b0;
    case (state)
      sdr_pkg::st_load_mode: begin
        cmd = sdr_pkg::cmd_load_mode;
        a   = mode_word;
      end
      sdr_pkg::st_activate_wait: begin
        if (cnt == cnt_w'(`SDR_TRCD)) begin
          cmd = sdr_pkg::cmd_active;
          a   = 13'(cur.req.row);
          ba  = cur.req.bank;
        end
      end
      sdr_pkg::st_access: begin
        a  = 13'(cur.req.col);
        ba = cur.req.bank;
        if (cur.req.wr) begin
          cmd      = sdr_pkg::cmd_write;
          dqm      = cur.req.mask;
          dq_wr    = cur.req.wdata;
          dq_wr_en = 1'b1;
        end else begin
          cmd = sdr_pkg::cmd_read;
        end
      end
      default: ;
    endcase
  end

  assign {cs, ras, cas, we} = cmd;
  assign rd_issue = (cmd == sdr_pkg::cmd_read);
  assign rd_tag   = cur.req.tag;

endmodule

//--- src/sdr_device.sv
`include "sdr_settings.svh"

module sdr_device (
  input  logic        clk,
  input  logic        cs,
  input  logic        ras,
  input  logic        cas,
  input  logic        we,
  input  logic [12:0] a,
  input  logic [1:0]  ba,
  input  logic [1:0]  dqm,
  input  logic [15:0] dq_wr,
  input  logic        dq_wr_en,
  output logic [15:0] dq_rd
);

  localparam int rows = 2 ** `SDR_ROW_BITS;
  localparam int cols = 2 ** `SDR_COL_BITS;

  logic [15:0]              mem [4][rows][cols];
  logic [`SDR_ROW_BITS-1:0] row_addr [4];
  logic [2:0]               cas_latency;
  logic [1:0]               bank_q;
  logic [`SDR_COL_BITS-1:0] col_q;
  logic [`SDR_COL_BITS-1:0] col_w;
  logic [15:0]              old_word;
  logic [15:0]              data_in;
  logic [15:0]              data_out;
  logic [15:0]              data_out_p;
  logic [15:0]              data_out_2p;
  logic                     do_write;
  sdr_pkg::sdr_cmd_e        cmd;

  assign cmd      = sdr_pkg::sdr_cmd_e'({cs, ras, cas, we});
  assign do_write = (cmd == sdr_pkg::cmd_write) && dq_wr_en;

  initial begin
    for (int b = 0; b < 4; b++)
      for (int r = 0; r < rows; r++)
        for (int c = 0; c < cols; c++)
          mem[b][r][c] = '0;
  end

  always_ff @(posedge clk) begin
    if (cmd == sdr_pkg::cmd_load_mode) cas_latency <= a[6:4];
    if (cmd == sdr_pkg::cmd_active) row_addr[ba] <= a[`SDR_ROW_BITS-1:0];
    if (cmd == sdr_pkg::cmd_read) begin
      bank_q <= ba;
      col_q  <= a[`SDR_COL_BITS-1:0];
    end
  end

  // Masked bytes come from the stored word.
  assign col_w    = a[`SDR_COL_BITS-1:0];
  assign old_word = mem[ba][row_addr[ba]][col_w];
  assign data_in  = {dqm[1] ? old_word[15:8] : dq_wr[15:8],
                     dqm[0] ? old_word[7:0]  : dq_wr[7:0]};

  always_ff @(posedge clk) begin
    if (do_write) mem[ba][row_addr[ba]][col_w] <= data_in;
  end

  // Read path delay line, tapped by the loaded CAS latency.
  assign data_out = mem[bank_q][row_addr[bank_q]][col_q];

  always_ff @(posedge clk) begin
    data_out_p  <= data_out;
    data_out_2p <= data_out_p;
  end

  assign dq_rd = (cas_latency == 3'd2) ? data_out_p : data_out_2p;

endmodule

//--- src/sdr_read_capture.sv
`include "sdr_settings.svh"

module sdr_read_capture (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     rd_issue,
  input  logic [`SDR_TAG_BITS-1:0] rd_tag,
  input  logic [15:0]              dq_rd,
  output sdr_pkg::sdr_rsp_t        rsp,
  output logic                     rsp_valid
);

  localparam int cl = `SDR_CAS_LATENCY;

  logic [cl-1:0]            pipe_vld;
  logic [`SDR_TAG_BITS-1:0] pipe_tag [cl];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pipe_vld  <= '0;
      rsp_valid <= 1'b0;
    end else begin
      pipe_vld  <= {pipe_vld[cl-2:0], rd_issue};
      rsp_valid <= pipe_vld[cl-1];
    end
  end

  // Tags ride along with the valid bits.
  always_ff @(posedge clk) begin
    pipe_tag[0] <= rd_tag;
    for (int i = 1; i < cl; i++) begin
      pipe_tag[i] <= pipe_tag[i-1];
    end
  end

  // Last stage lines up with the data on the return bus.
  always_ff @(posedge clk) begin
    if (pipe_vld[cl-1]) begin
      rsp.rdata <= dq_rd;
      rsp.tag   <= pipe_tag[cl-1];
    end
  end

endmodule

//--- src/sdr_subsystem.sv
`include "sdr_settings.svh"

module sdr_subsystem (
  input  logic              clk,
  input  logic              rst_n,
  input  sdr_pkg::sdr_req_t req,
  input  logic              req_valid,
  output logic              req_ready,
  output sdr_pkg::sdr_rsp_t rsp,
  output logic              rsp_valid
);

  sdr_pkg::sdr_plan_t       plan;
  logic                     plan_valid;
  logic                     plan_ready;
  logic                     cs;
  logic                     ras;
  logic                     cas;
  logic                     we;
  logic [12:0]              a;
  logic [1:0]               ba;
  logic [1:0]               dqm;
  logic [15:0]              dq_wr;
  logic                     dq_wr_en;
  logic [15:0]              dq_rd;
  logic                     rd_issue;
  logic [`SDR_TAG_BITS-1:0] rd_tag;

  sdr_row_tracker i_tracker (
    .clk, .rst_n, .req, .req_valid, .req_ready, .plan, .plan_valid, .plan_ready
  );

  sdr_cmd_issue i_issue (
    .clk, .rst_n, .plan, .plan_valid, .plan_ready, .cs, .ras, .cas, .we, .a, .ba,
    .dqm, .dq_wr, .dq_wr_en, .rd_issue, .rd_tag
  );

  sdr_device i_device (
    .clk, .cs, .ras, .cas, .we, .a, .ba, .dqm, .dq_wr, .dq_wr_en, .dq_rd
  );

  sdr_read_capture i_capture (
    .clk, .rst_n, .rd_issue, .rd_tag, .dq_rd, .rsp, .rsp_valid
  );

endmodule

//--- tb/sdr_properties.sv
`include "sdr_settings.svh"

module sdr_properties (
  input logic              clk,
  input logic              rst_n,
  input sdr_pkg::sdr_req_t req,
  input logic              req_valid,
  input logic              req_ready,
  input logic              rsp_valid,
  input logic              cs,
  input logic              ras,
  input logic              cas,
  input logic              we,
  input logic [1:0]        ba
);

  localparam logic [2:0] cl = 3'(`SDR_CAS_LATENCY);

  sdr_pkg::sdr_cmd_e cmd;
  logic [3:0]        bank_active;
  logic [2:0]        since_rst;

  assign cmd = sdr_pkg::sdr_cmd_e'({cs, ras, cas, we});

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bank_active <= '0;
      since_rst   <= '0;
    end else begin
      if (cmd == sdr_pkg::cmd_active) bank_active[ba] <= 1'b1;
      if (since_rst < cl) since_rst <= since_rst + 3'd1;
    end
  end

  req_held: assert property (@(posedge clk) disable iff (!rst_n)
    req_valid && !req_ready |=> req_valid && $stable(req))
    else $error("request dropped or changed while stalled");

  // Accesses only go to banks that have seen an activate.
  bank_opened: assert property (@(posedge clk) disable iff (!rst_n)
    (cmd == sdr_pkg::cmd_read || cmd == sdr_pkg::cmd_write) |-> bank_active[ba])
    else $error("access command to a bank that was never activated");

  rsp_quiet: assert property (@(posedge clk)
    (since_rst < cl) |-> !rsp_valid)
    else $error("read response too soon after reset");

endmodule

bind sdr_subsystem sdr_properties i_props (
  .clk, .rst_n, .req, .req_valid, .req_ready, .rsp_valid, .cs, .ras, .cas, .we, .ba
);

//--- tb/sdr_tb.sv
`include "sdr_settings.svh"

module sdr_tb;

  localparam int num_reqs       = 400;
  localparam int row_bits       = `SDR_ROW_BITS;
  localparam int col_bits       = `SDR_COL_BITS;
  localparam int tag_bits       = `SDR_TAG_BITS;
  localparam int rows           = 2 ** row_bits;
  localparam int cols           = 2 ** col_bits;
  localparam int timeout_cycles = `SDR_INIT_CYCLES + 10
                                  + num_reqs * (`SDR_TRCD + `SDR_CAS_LATENCY + 6);

  logic              clk = 1'b0;
  logic              rst_n;
  sdr_pkg::sdr_req_t req;
  logic              req_valid;
  logic              req_ready;
  sdr_pkg::sdr_rsp_t rsp;
  logic              rsp_valid;

  logic [15:0]       model_mem [4][rows][cols];
  sdr_pkg::sdr_rsp_t exp_q [$];
  int                cycles = 0;

  sdr_subsystem i_dut (
    .clk, .rst_n, .req, .req_valid, .req_ready, .rsp, .rsp_valid
  );

  always #4 clk = ~clk;

  task automatic stop_run(string line);
    $display("%s", line);
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_rsp(sdr_pkg::sdr_rsp_t got, sdr_pkg::sdr_rsp_t exp);
    if (got !== exp) begin
      stop_run($sformatf("error at %0t: read response data %h tag %h, expected data %h tag %h",
                         $time, got.rdata, got.tag, exp.rdata, exp.tag));
    end
  endtask

  // Called one unit after the edge that releases reset.
  task automatic check_ready_wait(int limit);
    int waited;
    waited = 0;
    if (req_ready) begin
      stop_run($sformatf("error at %0t: req_ready high right after reset", $time));
    end
    while (!req_ready) begin
      if (waited == limit) begin
        stop_run($sformatf("error at %0t: req_ready still low %0d cycles after reset",
                           $time, limit));
      end
      @(posedge clk);
      #1;
      waited++;
    end
    // The init wait and the mode load both come before the first request.
    if (waited <= `SDR_INIT_CYCLES) begin
      stop_run($sformatf("error at %0t: req_ready rose %0d cycles after reset, before init",
                         $time, waited));
    end
  endtask

  // Two rows per bank and a few columns, so reads hit written data and rows switch often.
  function automatic sdr_pkg::sdr_req_t make_req(int idx);
    sdr_pkg::sdr_req_t r;
    r.wr   = 1'($urandom_range(1));
    r.bank = 2'($urandom_range(3));
    if ($urandom_range(7) == 0) begin
      r.row = row_bits'($urandom);
      r.col = col_bits'($urandom);
    end else begin
      r.row = row_bits'(($urandom_range(1) == 1 ? 5 : 2) + int'(r.bank));
      r.col = col_bits'($urandom_range(3));
    end
    r.wdata = 16'($urandom);
    r.mask  = ($urandom_range(3) == 0) ? 2'($urandom_range(3)) : 2'b00;
    r.tag   = tag_bits'(idx);
    return r;
  endfunction

  task automatic apply_model(sdr_pkg::sdr_req_t r);
    logic [15:0]       old;
    sdr_pkg::sdr_rsp_t e;
    old = model_mem[r.bank][r.row][r.col];
    if (r.wr) begin
      model_mem[r.bank][r.row][r.col] = {r.mask[1] ? old[15:8] : r.wdata[15:8],
                                         r.mask[0] ? old[7:0]  : r.wdata[7:0]};
    end else begin
      e.rdata = old;
      e.tag   = r.tag;
      exp_q.push_back(e);
    end
  endtask

  always @(posedge clk) begin
    cycles++;
    if (cycles == timeout_cycles) begin
      stop_run($sformatf("timeout: run did not finish within %0d cycles", timeout_cycles));
    end
  end

  // Responses are registered, so mid-cycle they are settled.
  always @(negedge clk) begin
    if (rst_n && rsp_valid) begin
      if (exp_q.size() == 0) begin
        stop_run($sformatf("unexpected read response at %0t with no read outstanding", $time));
      end else begin
        check_rsp(rsp, exp_q.pop_front());
      end
    end
  end

  initial begin
    int   sent;
    int   gap;
    logic fire;
    void'($urandom(78));
    rst_n     = 1'b0;
    req       = '0;
    req_valid = 1'b0;
    for (int b = 0; b < 4; b++)
      for (int r = 0; r < rows; r++)
        for (int c = 0; c < cols; c++)
          model_mem[b][r][c] = '0;
    repeat (5) @(posedge clk);
    #1 rst_n = 1'b1;
    check_ready_wait(`SDR_INIT_CYCLES + 3);

    sent = 0;
    gap  = 0;
    while (sent < num_reqs) begin
      @(negedge clk);
      fire = req_valid && req_ready;
      @(posedge clk);
      #1;
      if (fire) begin
        apply_model(req);
        sent++;
        req_valid = 1'b0;
        gap = ($urandom_range(1) == 1) ? int'($urandom_range(3)) : 0;
      end
      if (!req_valid && sent < num_reqs) begin
        if (gap > 0) begin
          gap--;
        end else begin
          req       = make_req(sent);
          req_valid = 1'b1;
        end
      end
    end

    while (exp_q.size() != 0) @(posedge clk);
    // Time for the plan register and the issuer to drain, so a stray response still shows.
    repeat (2 * (`SDR_TRCD + 3) + `SDR_CAS_LATENCY + 2) @(posedge clk);
    $display("=== PASS ===");
    $finish;
  end

endmodule

//--- sdr_subsystem.f
+incdir+src
src/sdr_pkg.sv
src/sdr_row_tracker.sv
src/sdr_cmd_issue.sv
src/sdr_device.sv
src/sdr_read_capture.sv
src/sdr_subsystem.sv
tb/sdr_properties.sv
tb/sdr_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it; the exit status reports pass or fail.
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert --top-module sdr_tb -f sdr_subsystem.f -o sdr_sim \
  && ./obj_dir/sdr_sim \
  || { echo "simulation failed"; exit 1; }
